// File: copperv.f
common/copperv_pkg.sv
hdl/alu.sv
hdl/idecoder.sv
hdl/reg_file.sv
hdl/fetch_unit.sv
hdl/control_unit.sv
hdl/copperv.sv
testbench/copperv_assert.sv
testbench/copperv_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the copperv testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f copperv.f --top-module copperv_tb -o copperv_sim

output=$(./obj_dir/copperv_sim)
echo "$output"

if grep -q "TESTBENCH PASSED" <<< "$output"; then
    exit 0
else
    echo "Simulation did not pass"
    exit 1
fi

// File: testbench/copperv_tb.sv
`timescale 1ns/100ps

module copperv_tb import copperv_pkg::*; ();

    localparam int NUM_TESTS = 5;

    logic      clk = 1'b0;
    logic      rst = 1'b0;
    logic      arready = 1'b0;
    logic      rvalid = 1'b0;
    word_t     rdata = '0;
    logic      arvalid, rready, wb_valid;
    word_t     araddr, wb_data;
    reg_addr_t wb_addr;

    integer    seed = 70825;
    int        stall_max = 3;
    int        ar_delay, r_delay;
    int        mem_phase = 0;
    int        fetch_count = 0;
    int        errors = 0;
    int        tests_run = 0;
    int        tests_passed = 0;
    word_t     next_addr = RESET_PC;
    string     cur_test = "none";

    word_t     prog [$];
    word_t     shadow [32] = '{default: '0}; // Reference register file
    reg_addr_t exp_wb_addr [$], got_wb_addr [$];
    word_t     exp_wb_data [$], got_wb_data [$];

    copperv copperv_i (
        .clk, .rst, .arready, .rvalid, .rdata, .arvalid, .araddr, .rready,
        .wb_valid, .wb_addr, .wb_data
    );

    always #2 clk = ~clk;

    function automatic int draw_delay();
        return $unsigned($random(seed)) % (stall_max + 1);
    endfunction

    // Words past the program are zero, which the core treats as no-ops
    function automatic word_t fetch_word(input word_t addr);
        int idx;
        idx = int'(addr[31:2]);
        if (idx < prog.size())
            return prog[idx];
        return 32'h0000_0000;
    endfunction

    // RV32I OP-IMM semantics
    function automatic word_t ref_op_imm(input logic [2:0] f3, input word_t a,
                                         input logic [11:0] imm12);
        word_t      b;
        logic [4:0] sh;
        b = {{20{imm12[11]}}, imm12};
        sh = imm12[4:0];
        case (f3)
            3'b000: return a + b;
            3'b010: return {31'b0, $signed(a) < $signed(b)};
            3'b011: return {31'b0, a < b};
            3'b100: return a ^ b;
            3'b110: return a | b;
            3'b111: return a & b;
            3'b001: return a << sh;
            default: begin
                if (imm12[10])
                    return word_t'($signed(a) >>> sh);
                return a >> sh;
            end
        endcase
    endfunction

    // AXI4-Lite read slave
    always @(negedge clk) begin
        if (!rst) begin
            arready <= 1'b0;
            rvalid <= 1'b0;
            mem_phase = 0;
            fetch_count = 0;
            next_addr = RESET_PC;
            ar_delay = draw_delay();
        end else if (mem_phase == 0 && arvalid) begin
            if (ar_delay > 0) begin
                ar_delay--;
            end else begin
                arready <= 1'b1;
                if (araddr !== next_addr) begin
                    errors++;
                    $display("FAILED %s: fetch address expected %h actual %h",
                             cur_test, next_addr, araddr);
                end
                next_addr = next_addr + 32'd4;
                fetch_count++;
                mem_phase = 1;
            end
        end else if (mem_phase == 1) begin
            arready <= 1'b0; // Taken on the last rising edge
            r_delay = draw_delay();
            mem_phase = 2;
        end else if (mem_phase == 2) begin
            // Master must wait for the beat from AR acceptance on
            if (rready !== 1'b1) begin
                errors++;
                $display("FAILED %s: rready expected 1 actual %b", cur_test, rready);
            end
            if (r_delay > 0) begin
                r_delay--;
            end else begin
                rvalid <= 1'b1;
                rdata <= fetch_word(araddr);
                mem_phase = 3;
            end
        end else if (mem_phase == 3) begin
            rvalid <= 1'b0;
            ar_delay = draw_delay();
            mem_phase = 0;
        end
    end

    task automatic new_program();
        prog.delete();
        exp_wb_addr.delete();
        exp_wb_data.delete();
    endtask

    task automatic add_lui(input reg_addr_t rd, input logic [19:0] imm20);
        prog.push_back({imm20, rd, OPCODE_LUI});
        exp_wb_addr.push_back(rd);
        exp_wb_data.push_back({imm20, 12'h000});
        if (rd != 5'd0)
            shadow[rd] = {imm20, 12'h000};
    endtask

    task automatic add_opimm(input logic [2:0] f3, input reg_addr_t rd, input reg_addr_t rs1,
                             input logic [11:0] imm12);
        word_t res;
        res = ref_op_imm(f3, shadow[rs1], imm12);
        prog.push_back({imm12, rs1, f3, rd, OPCODE_OP_IMM});
        exp_wb_addr.push_back(rd);
        exp_wb_data.push_back(res);
        if (rd != 5'd0)
            shadow[rd] = res;
    endtask

    // k picks one of the nine OP-IMM instructions
    task automatic add_random_op(input int k, input reg_addr_t rd, input reg_addr_t rs1);
        logic [31:0] r;
        logic [2:0]  f3;
        logic [11:0] imm12;
        r = $random(seed);
        imm12 = r[11:0];
        case (k)
            0: f3 = 3'b000;
            1: f3 = 3'b010;
            2: f3 = 3'b011;
            3: f3 = 3'b100;
            4: f3 = 3'b110;
            5: f3 = 3'b111;
            6: f3 = 3'b001;
            default: f3 = 3'b101;
        endcase
        if (k >= 6)
            imm12 = {1'b0, k == 8, 5'b00000, r[4:0]}; // SRAI sets bit 30
        add_opimm(f3, rd, rs1, imm12);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst <= 1'b0;
        repeat (2) @(negedge clk);
        rst <= 1'b1;
    endtask

    task automatic run_program(input string name);
        int err_start;
        int i;
        err_start = errors;
        cur_test = name;
        got_wb_addr.delete();
        got_wb_data.delete();
        apply_reset();
        while (got_wb_addr.size() < exp_wb_addr.size()) begin
            @(negedge clk);
            if (wb_valid) begin
                got_wb_addr.push_back(wb_addr);
                got_wb_data.push_back(wb_data);
            end
        end
        for (i = 0; i < exp_wb_addr.size(); i++) begin
            if (got_wb_addr[i] !== exp_wb_addr[i] || got_wb_data[i] !== exp_wb_data[i]) begin
                errors++;
                $display("FAILED %s: write %0d expected x%0d=%h actual x%0d=%h", name, i,
                         exp_wb_addr[i], exp_wb_data[i], got_wb_addr[i], got_wb_data[i]);
            end
        end
        if (fetch_count < prog.size()) begin
            errors++;
            $display("FAILED %s: fetches expected at least %0d actual %0d",
                     name, prog.size(), fetch_count);
        end
        tests_run++;
        if (errors == err_start) begin
            tests_passed++;
            $display("test %s passed", name);
        end else begin
            $display("test %s failed with %0d errors", name, errors - err_start);
        end
    endtask

    task automatic test_reset_fetch();
        new_program();
        prog.push_back(32'h0000_0000);
        prog.push_back(32'h0000_0000);
        prog.push_back(32'h0000_0000);
        add_lui(5'd5, 20'h12345); // Fourth word, address 0xc
        run_program("reset_fetch");
    endtask

    task automatic test_lui();
        logic [31:0] r;
        int i;
        new_program();
        add_lui(5'd1, 20'hFFFFF);
        add_lui(5'd2, 20'h00001);
        for (i = 3; i < 9; i++) begin
            r = $random(seed);
            add_lui(reg_addr_t'(i), r[19:0]);
        end
        run_program("lui");
    endtask

    task automatic test_int_imm();
        logic [31:0] r;
        int k;
        new_program();
        r = $random(seed);
        add_lui(5'd1, r[31:12]);
        add_opimm(3'b000, 5'd1, 5'd1, r[11:0]);
        r = $random(seed);
        add_lui(5'd2, {1'b1, r[30:12]}); // Negative source for SRAI and SLT
        add_opimm(3'b000, 5'd2, 5'd2, r[11:0]);
        for (k = 0; k < 9; k++) begin
            add_random_op(k, reg_addr_t'(10 + k), 5'd1);
            add_random_op(k, reg_addr_t'(20 + k), 5'd2);
        end
        run_program("int_imm");
    endtask

    task automatic test_x0_other();
        new_program();
        add_opimm(3'b000, 5'd0, 5'd0, 12'h123);
        add_lui(5'd0, 20'hABCDE);
        add_opimm(3'b000, 5'd6, 5'd0, 12'h005); // x0 still reads zero
        prog.push_back(32'h0000_0033);    // ADD
        prog.push_back(32'h4000_1013);    // SLLI, bad funct7
        prog.push_back(32'h0000_2003);    // LW
        prog.push_back(32'h0000_006F);    // JAL
        add_opimm(3'b000, 5'd7, 5'd6, 12'hFFF);
        add_opimm(3'b100, 5'd8, 5'd0, 12'h800);
        run_program("x0_other");
    endtask

    task automatic test_backpressure();
        logic [31:0] r;
        int i;
        stall_max = 24;
        new_program();
        r = $random(seed);
        add_lui(5'd10, r[31:12]);
        for (i = 0; i < 16; i++) begin
            r = $random(seed);
            // Each op reads the previous result
            add_random_op(int'(r[7:0]) % 9, reg_addr_t'(i % 8 + 3), reg_addr_t'((i + 7) % 8 + 3));
        end
        run_program("backpressure");
        stall_max = 3;
    endtask

    initial begin
        #(NUM_TESTS * 64 * 12 * 4);
        $display("Watchdog timeout, the tests did not finish in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        test_reset_fetch();
        test_lui();
        test_int_imm();
        test_x0_other();
        test_backpressure();
        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_passed, tests_run - tests_passed, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/copperv_assert.sv
`timescale 1ns/100ps

module copperv_assert import copperv_pkg::*; (
    input logic   clk,
    input logic   rst,
    input logic   arvalid,
    input logic   arready,
    input word_t  araddr,
    input logic   rd_en,
    input state_t state
);

    // AR request held until the slave takes it
    ar_hold: assert property (@(posedge clk) disable iff (!rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("arvalid or araddr changed before arready");

    no_write_early: assert property (@(posedge clk) disable iff (!rst)
        !(rd_en && (state == STATE_IDLE || state == STATE_FETCH)))
        else $error("rd_en high in IDLE or FETCH");

    ar_reset: assert property (@(posedge clk) !rst |=> !arvalid)
        else $error("arvalid high during reset");

endmodule

bind copperv copperv_assert copperv_assert_i (
    .clk, .rst, .arvalid, .arready, .araddr, .rd_en, .state(control_unit_i.state)
);

// File: hdl/copperv.sv
`timescale 1ns/100ps

module copperv import copperv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      arready,
    input  logic      rvalid,
    input  word_t     rdata,
    output logic      arvalid,
    output word_t     araddr,
    output logic      rready,
    output logic      wb_valid,
    output reg_addr_t wb_addr,
    output word_t     wb_data
);

    logic          inst_fetch;
    logic          inst_valid;
    logic          rd_en;
    logic          rs1_en;
    logic          rs2_en;
    rd_din_sel_t   rd_din_sel;
    pc_next_sel_t  pc_next_sel;
    alu_din1_sel_t alu_din1_sel;
    alu_din2_sel_t alu_din2_sel;
    inst_type_t    inst_type;
    alu_op_t       alu_op;
    reg_addr_t     rd;
    reg_addr_t     rs1;
    reg_addr_t     rs2;
    word_t         inst;
    word_t         pc;
    word_t         imm;
    word_t         rs1_dout;
    word_t         rs2_dout;
    word_t         alu_din1;
    word_t         alu_din2;
    word_t         alu_dout;
    word_t         rd_din;

    control_unit control_unit_i (
        .clk, .rst, .inst_type, .inst_valid, .inst_fetch, .rd_en, .rs1_en, .rs2_en,
        .rd_din_sel, .pc_next_sel, .alu_din1_sel, .alu_din2_sel
    );

    fetch_unit fetch_unit_i (
        .clk, .rst, .inst_fetch, .pc_next_sel, .arready, .rvalid, .rdata,
        .arvalid, .araddr, .rready, .inst_valid, .inst, .pc
    );

    idecoder idecoder_i (.inst, .inst_type, .rd, .rs1, .rs2, .imm, .alu_op);

    reg_file reg_file_i (
        .clk, .rst, .rs1_en, .rs2_en, .rs1, .rs2, .rd, .rd_en, .rd_din,
        .rs1_dout, .rs2_dout
    );

    alu alu_i (.alu_op, .din1(alu_din1), .din2(alu_din2), .dout(alu_dout));

    // Operand and write-back muxes
    assign alu_din1 = (alu_din1_sel == ALU_DIN1_SEL_PC) ? pc : rs1_dout;
    assign alu_din2 = (alu_din2_sel == ALU_DIN2_SEL_RS2) ? rs2_dout : imm;
    assign rd_din   = (rd_din_sel == RD_DIN_SEL_ALU) ? alu_dout : imm;

    // Retire port
    assign wb_valid = rd_en;
    assign wb_addr  = rd;
    assign wb_data  = rd_din;

endmodule

// File: hdl/control_unit.sv
`timescale 1ns/100ps

module control_unit import copperv_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  inst_type_t    inst_type,
    input  logic          inst_valid,
    output logic          inst_fetch,
    output logic          rd_en,
    output logic          rs1_en,
    output logic          rs2_en,
    output rd_din_sel_t   rd_din_sel,
    output pc_next_sel_t  pc_next_sel,
    output alu_din1_sel_t alu_din1_sel,
    output alu_din2_sel_t alu_din2_sel
);

    state_t state;
    state_t state_next;

    always_ff @(posedge clk) begin
        if (!rst)
            state <= STATE_RESET;
        else
            state <= state_next;
    end

    always_comb begin
        state_next = STATE_FETCH;
        case (state)
            STATE_RESET: begin
                state_next = STATE_FETCH;
            end
            STATE_FETCH: begin
                state_next = STATE_IDLE;
            end
            STATE_IDLE: begin
                if (inst_valid)
                    state_next = STATE_LOAD;
                else
                    state_next = STATE_IDLE;
            end
            STATE_LOAD: begin
                // LUI retires here, everything else goes through EXEC
                if (inst_type == INST_TYPE_IMM)
                    state_next = STATE_FETCH;
                else
                    state_next = STATE_EXEC;
            end
            STATE_EXEC: begin
                state_next = STATE_FETCH;
            end
            STATE_MEM: begin
                state_next = STATE_FETCH; // Not entered
            end
            default: begin
                state_next = STATE_FETCH;
            end
        endcase
    end

    always_comb begin
        inst_fetch   = 1'b0;
        rd_en        = 1'b0;
        rs1_en       = 1'b0;
        rs2_en       = 1'b0; // No register-register ops yet
        rd_din_sel   = RD_DIN_SEL_IMM;
        pc_next_sel  = PC_NEXT_SEL_STALL;
        alu_din1_sel = ALU_DIN1_SEL_RS1;
        alu_din2_sel = ALU_DIN2_SEL_IMM;
        case (state)
            STATE_FETCH: begin
                inst_fetch  = 1'b1;
                pc_next_sel = PC_NEXT_SEL_INCR;
            end
            STATE_LOAD: begin
                case (inst_type)
                    INST_TYPE_IMM: begin
                        rd_en      = 1'b1;
                        rd_din_sel = RD_DIN_SEL_IMM;
                    end
                    INST_TYPE_INT_IMM: begin
                        rs1_en = 1'b1; // Operand ready for EXEC
                    end
                    default: begin
                    end
                endcase
            end
            STATE_EXEC: begin
                if (inst_type == INST_TYPE_INT_IMM) begin
                    rd_en        = 1'b1;
                    rd_din_sel   = RD_DIN_SEL_ALU;
                    alu_din1_sel = ALU_DIN1_SEL_RS1;
                    alu_din2_sel = ALU_DIN2_SEL_IMM;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// File: hdl/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit import copperv_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         inst_fetch,
    input  pc_next_sel_t pc_next_sel,
    input  logic         arready,
    input  logic         rvalid,
    input  word_t        rdata,
    output logic         arvalid,
    output word_t        araddr,
    output logic         rready,
    output logic         inst_valid,
    output word_t        inst,
    output word_t        pc
);

    typedef enum logic [1:0] {
        PHASE_IDLE,
        PHASE_ADDR,
        PHASE_DATA
    } phase_t;

    phase_t phase;

    always_ff @(posedge clk) begin
        if (!rst) begin
            phase      <= PHASE_IDLE;
            arvalid    <= 1'b0;
            rready     <= 1'b0;
            inst_valid <= 1'b0;
            pc         <= RESET_PC;
        end else begin
            inst_valid <= 1'b0;
            if (pc_next_sel == PC_NEXT_SEL_INCR)
                pc <= pc + word_t'(4);
            case (phase)
                PHASE_IDLE: begin
                    if (inst_fetch) begin
                        arvalid <= 1'b1;
                        phase   <= PHASE_ADDR;
                    end
                end
                PHASE_ADDR: begin
                    if (arready) begin // AR accepted
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        phase   <= PHASE_DATA;
                    end
                end
                PHASE_DATA: begin
                    if (rvalid) begin
                        rready     <= 1'b0;
                        inst_valid <= 1'b1;
                        phase      <= PHASE_IDLE;
                    end
                end
                default: phase <= PHASE_IDLE;
            endcase
        end
    end

    // Address and instruction registers
    always_ff @(posedge clk) begin
        if (phase == PHASE_IDLE && inst_fetch)
            araddr <= pc;
        if (phase == PHASE_DATA && rvalid)
            inst <= rdata;
    end

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/100ps

module reg_file import copperv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      rs1_en,
    input  logic      rs2_en,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  reg_addr_t rd,
    input  logic      rd_en,
    input  word_t     rd_din,
    output word_t     rs1_dout,
    output word_t     rs2_dout
);

    word_t regs [1:31]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (rd_en && rd != '0)
            regs[rd] <= rd_din;
    end

    // Held operands, valid the cycle after the enable
    always_ff @(posedge clk) begin
        if (!rst) begin
            rs1_dout <= '0;
            rs2_dout <= '0;
        end else begin
            if (rs1_en)
                rs1_dout <= (rs1 == '0) ? '0 : regs[rs1];
            if (rs2_en)
                rs2_dout <= (rs2 == '0) ? '0 : regs[rs2];
        end
    end

endmodule

// File: hdl/idecoder.sv
`timescale 1ns/100ps

module idecoder import copperv_pkg::*; (
    input  word_t      inst,
    output inst_type_t inst_type,
    output reg_addr_t  rd,
    output reg_addr_t  rs1,
    output reg_addr_t  rs2,
    output word_t      imm,
    output alu_op_t    alu_op
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign rd  = inst[11:7];
    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];

    // U-immediate for LUI, I-immediate for the rest
    assign imm = (opcode == OPCODE_LUI) ? {inst[31:12], 12'b0} :
                 {{(XLEN-12){inst[31]}}, inst[31:20]};

    always_comb begin
        inst_type = INST_TYPE_OTHER;
        alu_op    = ALU_ADD;
        case (opcode)
            OPCODE_LUI: begin
                inst_type = INST_TYPE_IMM;
            end
            OPCODE_OP_IMM: begin
                inst_type = INST_TYPE_INT_IMM;
                case (funct3)
                    3'b000: alu_op = ALU_ADD;
                    3'b010: alu_op = ALU_SLT;
                    3'b011: alu_op = ALU_SLTU;
                    3'b100: alu_op = ALU_XOR;
                    3'b110: alu_op = ALU_OR;
                    3'b111: alu_op = ALU_AND;
                    3'b001: begin
                        alu_op = ALU_SLL;
                        if (funct7 != 7'b0000000)
                            inst_type = INST_TYPE_OTHER;
                    end
                    3'b101: begin
                        // Bit 30 picks arithmetic shift
                        alu_op = inst[30] ? ALU_SRA : ALU_SRL;
                        if (funct7[6] || funct7[4:0] != 5'b00000)
                            inst_type = INST_TYPE_OTHER;
                    end
                    default: begin
                        inst_type = INST_TYPE_OTHER;
                    end
                endcase
            end
            default: begin
                inst_type = INST_TYPE_OTHER;
            end
        endcase
    end

endmodule

// File: hdl/alu.sv
`timescale 1ns/100ps

module alu import copperv_pkg::*; (
    input  alu_op_t alu_op,
    input  word_t   din1,
    input  word_t   din2,
    output word_t   dout
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = din2[4:0];
    assign lt_signed   = $signed(din1) < $signed(din2);
    assign lt_unsigned = din1 < din2;

    always_comb begin
        case (alu_op)
            ALU_ADD:  dout = din1 + din2;
            ALU_SLT:  dout = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: dout = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:  dout = din1 ^ din2;
            ALU_OR:   dout = din1 | din2;
            ALU_AND:  dout = din1 & din2;
            ALU_SLL:  dout = din1 << shamt;
            ALU_SRL:  dout = din1 >> shamt;
            ALU_SRA:  dout = word_t'($signed(din1) >>> shamt); // Sign fill
            default:  dout = din1 + din2;
        endcase
    end

endmodule

// File: common/copperv_pkg.sv
package copperv_pkg;

    // ISA widths
    localparam int XLEN           = 32;
    localparam int REG_ADDR_WIDTH = 5;

    typedef logic [XLEN-1:0]           word_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

    typedef logic [1:0] inst_type_t;
    localparam inst_type_t INST_TYPE_IMM     = 2'd0; // LUI
    localparam inst_type_t INST_TYPE_INT_IMM = 2'd1; // OP-IMM group
    localparam inst_type_t INST_TYPE_OTHER   = 2'd2;

    typedef logic rd_din_sel_t;
    localparam rd_din_sel_t RD_DIN_SEL_IMM = 1'b0;
    localparam rd_din_sel_t RD_DIN_SEL_ALU = 1'b1;

    typedef logic pc_next_sel_t;
    localparam pc_next_sel_t PC_NEXT_SEL_STALL = 1'b0;
    localparam pc_next_sel_t PC_NEXT_SEL_INCR  = 1'b1;

    typedef logic alu_din1_sel_t;
    localparam alu_din1_sel_t ALU_DIN1_SEL_RS1 = 1'b0;
    localparam alu_din1_sel_t ALU_DIN1_SEL_PC  = 1'b1;

    typedef logic alu_din2_sel_t;
    localparam alu_din2_sel_t ALU_DIN2_SEL_IMM = 1'b0;
    localparam alu_din2_sel_t ALU_DIN2_SEL_RS2 = 1'b1;

    typedef logic [3:0] alu_op_t;
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SLT  = 4'd1;
    localparam alu_op_t ALU_SLTU = 4'd2;
    localparam alu_op_t ALU_XOR  = 4'd3;
    localparam alu_op_t ALU_OR   = 4'd4;
    localparam alu_op_t ALU_AND  = 4'd5;
    localparam alu_op_t ALU_SLL  = 4'd6;
    localparam alu_op_t ALU_SRL  = 4'd7;
    localparam alu_op_t ALU_SRA  = 4'd8;

    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

    localparam word_t RESET_PC = 32'h0000_0000;

    // Core sequencing states
    typedef enum logic [2:0] {
        STATE_RESET,
        STATE_IDLE,
        STATE_FETCH,
        STATE_LOAD,
        STATE_EXEC,
        STATE_MEM // reserved
    } state_t;

endpackage
